/* Bender.yml */
package:
  name: item_map

sources:
  - design/itemMapPkg.sv
  - design/itemRandom.sv
  - design/placementGenerator.sv
  - design/moveQueue.sv
  - design/itemTable.sv
  - design/itemMapTop.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/itemMapTb.sv

/* design/itemMapPkg.sv */
/*
 * item map package: grid, generator and queue constants,
 * index and count types, item record and move request structs
 */
package itemMapPkg;

    // map capacity and grid size in cells
    localparam int MaxItems = 30;
    localparam int GridWidth = 20;
    localparam int GridHeight = 10;

    // stored coordinates carry 4 fraction bits, cell * 16
    localparam int FracBits = 4;

    // linear congruential source, next = (a * value + b) mod 512
    localparam logic [8:0] RandSeed = 9'd173;
    localparam int RandMulA = 43;
    localparam int RandAddB = 181;

    // fifo entries, also the credits a sender holds after reset
    localparam int MoveQueueDepth = 4;

    // index of one item, 0 to MaxItems - 1
    typedef logic [4:0] itemIndex_t;

    // number of placed items, 0 to MaxItems
    typedef logic [5:0] itemCount_t;

    // requested count of one kind
    typedef logic [4:0] quantity_t;

    typedef enum logic [1:0] {
        stone   = 2'd0,
        gold    = 2'd1,
        diamond = 2'd2
    } itemKind_t;

    // one item, 32 bits, msb first
    typedef struct packed {
        // column * 16
        logic [12:0] xPos;
        // row * 16
        logic [11:0] yPos;
        // always zero
        logic [2:0]  spare;
        itemKind_t   kind;
        logic        visible;
        logic        moved;
    } itemRecord_t;

    // sign-magnitude step, sign set means subtract
    typedef struct packed {
        logic       sign;
        logic [9:0] magnitude;
    } moveDelta_t;

    // one move request, 29 bits
    typedef struct packed {
        itemIndex_t index;
        moveDelta_t dx;
        moveDelta_t dy;
        logic       moved;
        logic       visible;
    } moveRequest_t;

endpackage

/* design/itemMapTop.sv */
/*
 * item map top level
 * random source, placement FSM, move FIFO and item table
 */
`timescale 1ns/1ps

module itemMapTop (
    input  logic                     clock,
    input  logic                     generateEn,
    input  itemMapPkg::quantity_t    stoneQuantity,
    input  itemMapPkg::quantity_t    goldQuantity,
    input  itemMapPkg::quantity_t    diamondQuantity,
    input  itemMapPkg::moveRequest_t moveReq,
    input  logic                     moveValid,
    output logic                     moveCredit,
    input  itemMapPkg::itemIndex_t   readIndex,
    output itemMapPkg::itemRecord_t  readItem,
    output itemMapPkg::itemCount_t   placedCount,
    output logic                     generationDone
);
    import itemMapPkg::*;

    // generator to random source
    logic         drawReq;
    logic [8:0]   randValue;
    // generator to table
    logic         placeWrite;
    itemIndex_t   placeIndex;
    itemRecord_t  placeRecord;
    // queue head to table
    moveRequest_t headReq;
    logic         headValid;
    logic         headPop;

    itemRandom random_i (
        .clock      (clock),
        .generateEn (generateEn),
        .drawReq    (drawReq),
        .randValue  (randValue)
    );

    placementGenerator generator_i (
        .clock           (clock),
        .generateEn      (generateEn),
        .stoneQuantity   (stoneQuantity),
        .goldQuantity    (goldQuantity),
        .diamondQuantity (diamondQuantity),
        .drawReq         (drawReq),
        .randValue       (randValue),
        .placeWrite      (placeWrite),
        .placeIndex      (placeIndex),
        .placeRecord     (placeRecord),
        .placedCount     (placedCount),
        .generationDone  (generationDone)
    );

    moveQueue queue_i (
        .clock      (clock),
        .generateEn (generateEn),
        .moveReq    (moveReq),
        .moveValid  (moveValid),
        .headReq    (headReq),
        .headValid  (headValid),
        .headPop    (headPop),
        .moveCredit (moveCredit)
    );

    itemTable table_i (
        .clock          (clock),
        .generateEn     (generateEn),
        .placeWrite     (placeWrite),
        .placeIndex     (placeIndex),
        .placeRecord    (placeRecord),
        .generationDone (generationDone),
        .placedCount    (placedCount),
        .headReq        (headReq),
        .headValid      (headValid),
        .headPop        (headPop),
        .readIndex      (readIndex),
        .readItem       (readItem)
    );

endmodule

/* design/itemRandom.sv */
/*
 * 9-bit linear congruential source
 * steps once per draw request, holds otherwise
 */
`timescale 1ns/1ps

module itemRandom (
    input  logic       clock,
    input  logic       generateEn,
    input  logic       drawReq,
    output logic [8:0] randValue
);
    import itemMapPkg::*;

    logic [8:0] nextValue;

    // 9-bit arithmetic wraps by itself, so this is already mod 512
    assign nextValue = 9'(RandMulA) * randValue + 9'(RandAddB);

    // back to the seed on every reset, so each run repeats its sequence
    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            randValue <= RandSeed;
        end else if (drawReq) begin
            randValue <= nextValue;
        end
    end

endmodule

/* design/itemTable.sv */
/*
 * item record storage
 * placement writes, move application from the queue head,
 * registered single read port
 */
`timescale 1ns/1ps

module itemTable (
    input  logic                     clock,
    input  logic                     generateEn,
    input  logic                     placeWrite,
    input  itemMapPkg::itemIndex_t   placeIndex,
    input  itemMapPkg::itemRecord_t  placeRecord,
    input  logic                     generationDone,
    input  itemMapPkg::itemCount_t   placedCount,
    input  itemMapPkg::moveRequest_t headReq,
    input  logic                     headValid,
    output logic                     headPop,
    input  itemMapPkg::itemIndex_t   readIndex,
    output itemMapPkg::itemRecord_t  readItem
);
    import itemMapPkg::*;

    itemRecord_t records [MaxItems];
    itemRecord_t target;
    itemRecord_t updated;
    logic        indexValid;

    // moves wait in the queue until the map is complete
    assign headPop = headValid && generationDone;

    // moves past the placed items are consumed without effect
    assign indexValid = ({1'b0, headReq.index} < placedCount);
    assign target = indexValid ? records[headReq.index] : '0;

    // apply the sign-magnitude steps, wrapping inside each field
    always_comb begin
        updated = target;
        if (headReq.dx.sign) begin
            updated.xPos = target.xPos - 13'(headReq.dx.magnitude);
        end else begin
            updated.xPos = target.xPos + 13'(headReq.dx.magnitude);
        end
        if (headReq.dy.sign) begin
            updated.yPos = target.yPos - 12'(headReq.dy.magnitude);
        end else begin
            updated.yPos = target.yPos + 12'(headReq.dy.magnitude);
        end
        // flags come straight from the request
        updated.moved = headReq.moved;
        updated.visible = headReq.visible;
    end

    always_ff @(posedge clock) begin
        if (placeWrite) begin
            records[placeIndex] <= placeRecord;
        end else if (headPop && indexValid) begin
            records[headReq.index] <= updated;
        end
        // indexes 30 and 31 read as zero
        if (int'(readIndex) < MaxItems) begin
            readItem <= records[readIndex];
        end else begin
            readItem <= '0;
        end
    end

    // placement and moves never overlap, generator and queue agree on done
    writeExclusive: assert property (
        @(posedge clock) disable iff (!generateEn)
        !(placeWrite && headPop)
    ) else $error("placement write and move pop in the same cycle");

    // no placement after the map was reported complete
    doneIsFinal: assert property (
        @(posedge clock) disable iff (!generateEn)
        generationDone |=> generationDone && !placeWrite
    ) else $error("placement activity after generation finished");

endmodule

/* design/moveQueue.sv */
/*
 * move request FIFO with credit return
 * one credit pulse for every request that leaves the queue
 */
`timescale 1ns/1ps

module moveQueue (
    input  logic                     clock,
    input  logic                     generateEn,
    input  itemMapPkg::moveRequest_t moveReq,
    input  logic                     moveValid,
    output itemMapPkg::moveRequest_t headReq,
    output logic                     headValid,
    input  logic                     headPop,
    output logic                     moveCredit
);
    import itemMapPkg::*;

    moveRequest_t entries [MoveQueueDepth];
    logic [$clog2(MoveQueueDepth)-1:0]   writePtr;
    logic [$clog2(MoveQueueDepth)-1:0]   readPtr;
    logic [$clog2(MoveQueueDepth+1)-1:0] fillCount;
    logic push;
    logic pop;
    logic full;

    assign full = (fillCount == MoveQueueDepth);
    // a push without a credit is dropped here and flagged below
    assign push = moveValid && !full;
    assign pop = headPop && headValid;

    assign headValid = (fillCount != '0);
    assign headReq = entries[readPtr];
    assign moveCredit = pop;

    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            writePtr <= '0;
            readPtr <= '0;
            fillCount <= '0;
        end else begin
            if (push) begin
                writePtr <= (int'(writePtr) == MoveQueueDepth - 1) ? '0 : writePtr + 1'b1;
            end
            if (pop) begin
                readPtr <= (int'(readPtr) == MoveQueueDepth - 1) ? '0 : readPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clock) begin
        if (push) begin
            entries[writePtr] <= moveReq;
        end
    end

    // the sender ran out of credits
    noPushWhenFull: assert property (
        @(posedge clock) disable iff (!generateEn)
        moveValid |-> !full
    ) else $error("move request sent without a credit");

    noPopWhenEmpty: assert property (
        @(posedge clock) disable iff (!generateEn)
        headPop |-> headValid
    ) else $error("move queue popped while empty");

endmodule

/* design/placementGenerator.sv */
/*
 * placement FSM: folds each random draw into a grid cell,
 * checks it serially against the used-cell memory, redraws on a hit
 * and writes one record per placed item
 */
`timescale 1ns/1ps

module placementGenerator (
    input  logic                    clock,
    input  logic                    generateEn,
    input  itemMapPkg::quantity_t   stoneQuantity,
    input  itemMapPkg::quantity_t   goldQuantity,
    input  itemMapPkg::quantity_t   diamondQuantity,
    output logic                    drawReq,
    input  logic [8:0]              randValue,
    output logic                    placeWrite,
    output itemMapPkg::itemIndex_t  placeIndex,
    output itemMapPkg::itemRecord_t placeRecord,
    output itemMapPkg::itemCount_t  placedCount,
    output logic                    generationDone
);
    import itemMapPkg::*;

    // one grid cell, column 1..20 and row 1..10
    typedef struct packed {
        logic [4:0] col;
        logic [3:0] row;
    } gridCell_t;

    typedef enum logic [1:0] {
        stateDraw,
        stateCheck,
        stateSave,
        stateDone
    } genState_t;

    genState_t  state;
    gridCell_t  folded;
    gridCell_t  candidate;
    gridCell_t  usedCells [MaxItems];
    itemIndex_t checkIndex;
    logic [4:0] xRaw;
    logic [3:0] yRaw;
    logic [6:0] quantitySum;
    logic       allPlaced;
    logic       checkedAll;
    logic       cellHit;

    // high 5 bits pick the column, low 4 bits the row
    assign xRaw = randValue[8:4];
    assign yRaw = randValue[3:0];

    // fold out-of-range draws back onto the grid
    assign folded.col = (xRaw >= GridWidth) ? 5'(2 * GridWidth - int'(xRaw))
                                            : 5'(GridWidth - int'(xRaw));
    assign folded.row = (yRaw >= GridHeight) ? 4'(2 * GridHeight - int'(yRaw))
                                             : 4'(GridHeight - int'(yRaw));

    // 7 bits so an oversized request is still visible to the check below
    assign quantitySum = 7'(stoneQuantity) + 7'(goldQuantity) + 7'(diamondQuantity);
    assign allPlaced = (7'(placedCount) == quantitySum);

    // compare against earlier placements only
    assign checkedAll = ({1'b0, checkIndex} >= placedCount);
    assign cellHit = (usedCells[checkIndex] == candidate);

    // one draw per candidate, taken as the candidate is latched
    assign drawReq = (state == stateDraw) && !allPlaced;
    assign placeWrite = (state == stateSave);
    assign generationDone = (state == stateDone);
    assign placeIndex = placedCount[4:0];

    // record for the current candidate
    always_comb begin
        placeRecord.xPos = 13'(candidate.col) << FracBits;
        placeRecord.yPos = 12'(candidate.row) << FracBits;
        placeRecord.spare = 3'b000;
        placeRecord.visible = 1'b1;
        placeRecord.moved = 1'b0;
        // stones first, then golds, then diamonds
        if (7'(placedCount) < 7'(stoneQuantity)) begin
            placeRecord.kind = stone;
        end else if (7'(placedCount) < 7'(stoneQuantity) + 7'(goldQuantity)) begin
            placeRecord.kind = gold;
        end else begin
            placeRecord.kind = diamond;
        end
    end

    always_ff @(posedge clock or negedge generateEn) begin
        if (!generateEn) begin
            state <= stateDraw;
            checkIndex <= '0;
            placedCount <= '0;
        end else begin
            case (state)
                stateDraw: begin
                    if (allPlaced) begin
                        state <= stateDone;
                    end else begin
                        checkIndex <= '0;
                        state <= stateCheck;
                    end
                end
                stateCheck: begin
                    if (checkedAll) begin
                        state <= stateSave;
                    end else if (cellHit) begin
                        // cell taken, new draw
                        state <= stateDraw;
                    end else begin
                        checkIndex <= checkIndex + 1'b1;
                    end
                end
                stateSave: begin
                    placedCount <= placedCount + 1'b1;
                    state <= stateDraw;
                end
                // done holds until the next reset
                default: state <= state;
            endcase
        end
    end

    // candidate and used-cell storage
    always_ff @(posedge clock) begin
        if (drawReq) begin
            candidate <= folded;
        end
        if (placeWrite) begin
            usedCells[placeIndex] <= candidate;
        end
    end

    quantityLimit: assert property (
        @(posedge clock) disable iff (!generateEn)
        quantitySum <= 7'(MaxItems)
    ) else $error("quantity sum %0d exceeds map capacity", quantitySum);

    // quantities are sampled all through generation
    quantityStable: assert property (
        @(posedge clock) disable iff (!generateEn)
        !generationDone && $past(!generationDone) |-> $stable(quantitySum)
    ) else $error("quantities changed while generation was running");

endmodule

/* filelist.f */
design/itemMapPkg.sv
design/itemRandom.sv
design/placementGenerator.sv
design/moveQueue.sv
design/itemTable.sv
design/itemMapTop.sv
tests/clockGen.sv
tests/itemMapTb.sv

/* tests/clockGen.sv */
/*
 * testbench clock, 40 ns period
 * active-low reset held for 8 cycles at start and on request
 */
`timescale 1ns/1ps

module clockGen (
    output logic clock,
    input  logic resetReq,
    output logic generateEn
);
    localparam int ResetCycles = 8;

    // starts loaded, so the DUT comes up in reset
    int resetCount = ResetCycles;

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    // reload on request, count down to release
    always @(posedge clock) begin
        if (resetReq) begin
            resetCount <= ResetCycles;
        end else if (resetCount > 0) begin
            resetCount <= resetCount - 1;
        end
    end

    assign generateEn = (resetCount == 0);

endmodule

/* tests/itemMapTb.sv */
/*
 * item map testbench
 * reads runs, placements, moves and records from the data file,
 * drives the DUT and checks every placed record against a model
 */
`timescale 1ns/1ps

module itemMapTb;
    import itemMapPkg::*;

    localparam string DataFile = "tests/itemMap_testdata.txt";
    localparam int RandomSeed = 22035;

    logic         clock;
    logic         generateEn;
    logic         resetReq;
    quantity_t    stoneQuantity;
    quantity_t    goldQuantity;
    quantity_t    diamondQuantity;
    moveRequest_t moveReq;
    logic         moveValid;
    logic         moveCredit;
    itemIndex_t   readIndex;
    itemRecord_t  readItem;
    itemCount_t   placedCount;
    logic         generationDone;

    // expected table, rebuilt for each run
    itemRecord_t model [MaxItems];
    int          cellCol [MaxItems];
    int          cellRow [MaxItems];
    string       lines [$];
    int          cycleCount = 0;
    int          cycleLimit = 0;
    int          creditPulses = 0;
    int          movesSent = 0;
    int          itemTotal = 0;
    int          stones = 0;
    int          golds = 0;
    logic        runOpen = 1'b0;

    clockGen clock_i (
        .clock      (clock),
        .resetReq   (resetReq),
        .generateEn (generateEn)
    );

    itemMapTop dut_i (
        .clock           (clock),
        .generateEn      (generateEn),
        .stoneQuantity   (stoneQuantity),
        .goldQuantity    (goldQuantity),
        .diamondQuantity (diamondQuantity),
        .moveReq         (moveReq),
        .moveValid       (moveValid),
        .moveCredit      (moveCredit),
        .readIndex       (readIndex),
        .readItem        (readItem),
        .placedCount     (placedCount),
        .generationDone  (generationDone)
    );

    task automatic stopOnFailure(input string message);
        $display("%s", message);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic checkFields(input int got, input int wanted, input string line);
        assert (got == wanted) else stopOnFailure({"malformed line in the data file: ", line});
    endtask

    // placed item: cell times 16, shown, not moved
    function automatic itemRecord_t placedRecord(input int col, input int row, input int kind);
        itemRecord_t rec;
        rec = '0;
        rec.xPos = 13'(col * 16);
        rec.yPos = 12'(row * 16);
        rec.kind = itemKind_t'(kind);
        rec.visible = 1'b1;
        return rec;
    endfunction

    // sign-magnitude step with field wraparound, flags copied
    function automatic void applyMove(input moveRequest_t req);
        itemRecord_t rec;
        if (int'(req.index) >= itemTotal) begin
            return;
        end
        rec = model[req.index];
        if (req.dx.sign) rec.xPos = rec.xPos - 13'(req.dx.magnitude);
        else rec.xPos = rec.xPos + 13'(req.dx.magnitude);
        if (req.dy.sign) rec.yPos = rec.yPos - 12'(req.dy.magnitude);
        else rec.yPos = rec.yPos + 12'(req.dy.magnitude);
        rec.moved = req.moved;
        rec.visible = req.visible;
        model[req.index] = rec;
    endfunction

    task automatic readRecord(input int index, output itemRecord_t rec);
        @(posedge clock);
        readIndex <= itemIndex_t'(index);
        @(posedge clock);
        @(negedge clock);
        rec = readItem;
    endtask

    // new reset with new quantities, returns once released
    task automatic startRun(input int s, input int g, input int d);
        @(posedge clock);
        resetReq <= 1'b1;
        @(posedge clock);
        resetReq <= 1'b0;
        @(posedge clock);
        stoneQuantity <= quantity_t'(s);
        goldQuantity <= quantity_t'(g);
        diamondQuantity <= quantity_t'(d);
        @(negedge clock);
        assert (!generateEn && !generationDone && !moveCredit && placedCount == '0) else
            stopOnFailure($sformatf("error at %0t: outputs not cleared in reset", $time));
        itemTotal = s + g + d;
        stones = s;
        golds = g;
        movesSent = 0;
        while (!generateEn) @(posedge clock);
    endtask

    task automatic sendMove(input moveRequest_t req);
        int gap;
        gap = $urandom_range(2);
        // wait while every credit is in flight
        while (movesSent - creditPulses >= MoveQueueDepth) @(posedge clock);
        repeat (gap) @(posedge clock);
        @(posedge clock);
        moveReq <= req;
        moveValid <= 1'b1;
        movesSent++;
        @(posedge clock);
        moveValid <= 1'b0;
    endtask

    // generation done, queue drained, whole table matches the model
    task automatic settleRun();
        itemRecord_t rec;
        while (!generationDone) @(negedge clock);
        assert (int'(placedCount) == itemTotal) else stopOnFailure($sformatf(
            "error at %0t: placedCount %0d, expected %0d", $time, placedCount, itemTotal));
        while (creditPulses < movesSent) @(negedge clock);
        repeat (2) @(negedge clock);
        assert (creditPulses == movesSent) else stopOnFailure($sformatf(
            "error at %0t: %0d credit pulses for %0d moves", $time, creditPulses, movesSent));
        for (int i = 0; i < itemTotal; i++) begin
            readRecord(i, rec);
            assert (rec == model[i]) else stopOnFailure($sformatf(
                "error at %0t: item %0d reads %h, expected %h", $time, i, rec, model[i]));
        end
        runOpen = 1'b0;
    endtask

    // credit count, early credit check, cycle limit
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (!generateEn) creditPulses <= 0;
        else if (moveCredit) creditPulses <= creditPulses + 1;
        assert (!(moveCredit && !generationDone)) else
            stopOnFailure($sformatf("error at %0t: moveCredit before generationDone", $time));
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            stopOnFailure($sformatf("timeout: no finish within %0d clock cycles", cycleLimit));
        end
    end

    initial begin
        int fd;
        int count;
        int runCount;
        int moveCount;
        int kindRule;
        int field [8];
        string line;
        itemRecord_t rec;
        itemRecord_t fileRec;
        moveRequest_t req;
        void'($urandom(RandomSeed));
        resetReq = 1'b0;
        stoneQuantity = '0;
        goldQuantity = '0;
        diamondQuantity = '0;
        moveReq = '0;
        moveValid = 1'b0;
        readIndex = '0;
        runCount = 0;
        moveCount = 0;
        fd = $fopen(DataFile, "r");
        if (fd == 0) stopOnFailure({"could not open the data file ", DataFile});
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
                if (line.getc(0) == "R") runCount++;
                if (line.getc(0) == "M") moveCount++;
            end
        end
        $fclose(fd);
        cycleLimit = runCount * (MaxItems * MaxItems * 4) + moveCount * 10 + 200;

        foreach (lines[n]) begin
            line = lines[n];
            case (line.getc(0))
                "R": begin
                    if (runOpen) settleRun();
                    count = $sscanf(line, "R %d %d %d", field[0], field[1], field[2]);
                    checkFields(count, 3, line);
                    startRun(field[0], field[1], field[2]);
                    runOpen = 1'b1;
                end
                "P": begin
                    count = $sscanf(line, "P %d %d %d %d", field[0], field[1], field[2],
                        field[3]);
                    checkFields(count, 4, line);
                    // stones first, then golds, then diamonds
                    kindRule = (field[0] < stones) ? 0 : (field[0] < stones + golds) ? 1 : 2;
                    assert (field[3] == kindRule) else stopOnFailure($sformatf(
                        "error at %0t: item %0d kind %0d breaks index order", $time,
                        field[0], field[3]));
                    assert (field[1] >= 1 && field[1] <= GridWidth && field[2] >= 1 &&
                        field[2] <= GridHeight) else stopOnFailure($sformatf(
                        "error at %0t: item %0d lies off the grid", $time, field[0]));
                    for (int k = 0; k < field[0]; k++) begin
                        assert (cellCol[k] != field[1] || cellRow[k] != field[2]) else
                            stopOnFailure($sformatf("error at %0t: items %0d and %0d share a cell",
                                $time, k, field[0]));
                    end
                    cellCol[field[0]] = field[1];
                    cellRow[field[0]] = field[2];
                    model[field[0]] = placedRecord(field[1], field[2], kindRule);
                end
                "M": begin
                    count = $sscanf(line, "M %d %d %d %d %d %d %d", field[0], field[1],
                        field[2], field[3], field[4], field[5], field[6]);
                    checkFields(count, 7, line);
                    req.index = itemIndex_t'(field[0]);
                    req.dx.sign = field[1][0];
                    req.dx.magnitude = 10'(field[2]);
                    req.dy.sign = field[3][0];
                    req.dy.magnitude = 10'(field[4]);
                    req.moved = field[5][0];
                    req.visible = field[6][0];
                    sendMove(req);
                    applyMove(req);
                end
                "E": begin
                    if (runOpen) settleRun();
                    count = $sscanf(line, "E %d %h", field[0], field[1]);
                    checkFields(count, 2, line);
                    fileRec = itemRecord_t'(field[1]);
                    assert (fileRec == model[field[0]]) else stopOnFailure($sformatf(
                        "error at %0t: file record %h for item %0d, rule gives %h", $time,
                        fileRec, field[0], model[field[0]]));
                    readRecord(field[0], rec);
                    assert (rec == fileRec) else stopOnFailure($sformatf(
                        "error at %0t: item %0d reads %h, expected %h", $time, field[0], rec,
                        fileRec));
                end
                default: stopOnFailure({"unknown line type in the data file: ", line});
            endcase
        end
        if (runOpen) settleRun();
        $display("** PASS **");
        $finish;
    end

endmodule

/* tests/itemMap_testdata.txt */
# R stones golds diamonds | P index col row kind | M index dxSign dxMag dySign dyMag moved visible
# E index record in hex: xPos 13, yPos 12, spare 3, kind 2, visible, moved
R 3 2 1
P 0 10 7 0
P 1 12 6 0
P 2 10 9 0
P 3 12 10 1
P 4 9 5 1
P 5 7 8 2
M 1 0 5 1 16 1 1
M 4 1 144 0 0 1 0
M 9 0 3 0 3 1 1
M 0 1 200 0 1000 1 1
M 1 1 5 0 16 0 1
E 0 FEC22C03
E 1 06003002
E 2 05004802
E 4 00002805
E 5 0380400A
R 1 1 2
P 0 10 7 0
P 1 12 6 1
P 2 10 9 2
P 3 12 10 2
M 3 0 0 1 160 1 1
M 4 0 1 0 1 1 1
E 3 0600000B
E 1 06003006
E 0 05003802
